// ==== Makefile ====
TOP ?= multiLaneScalerTb
FILELIST ?= multiLaneScaler.f
BUILD_DIR ?= build
LOG ?= sim.log
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -j 0
FAIL_TEXT ?= Simulation failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== multiLaneScaler.f ====
rtl/scalerPkg.sv
rtl/sampleFifo.sv
rtl/shiftSaturate.sv
rtl/gainLane.sv
rtl/laneDispatcher.sv
rtl/laneCollector.sv
rtl/multiLaneScaler.sv
verification/multiLaneScalerTb.sv

// ==== rtl/gainLane.sv ====
`timescale 1ns/1ps

module gainLane (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cfgWrite,
    input  scalerPkg::gainT   cfgGain,
    input  scalerPkg::shiftT  cfgShift,
    input  logic              inValid,
    input  scalerPkg::sampleT inSample,
    output logic              laneCredit,
    input  logic              outPop,
    output scalerPkg::resultT outData,
    output logic              outNotEmpty
);

    scalerPkg::gainT gainReg;
    scalerPkg::shiftT shiftReg;
    scalerPkg::sampleT inHead;
    logic inNotEmpty;
    logic inPop;
    scalerPkg::productT product;
    scalerPkg::shiftT productShift;
    logic productValid;
    scalerPkg::resultT result;
    logic resultValid;
    scalerPkg::laneCntT outCount;
    scalerPkg::laneCntT inFlight;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gainReg <= '0;
            shiftReg <= '0;
        end else if (cfgWrite) begin
            gainReg <= cfgGain;
            shiftReg <= cfgShift;
        end
    end

    sampleFifo #(
        .payloadT (scalerPkg::sampleT),
        .depth    (scalerPkg::laneDepth)
    ) i_inFifo (
        .clk      (clk),
        .arstN    (arstN),
        .push     (inValid),
        .pushData (inSample),
        .pop      (inPop),
        .popData  (inHead),
        .notEmpty (inNotEmpty),
        .count    ()
    );

    // Samples already in the pipeline hold a reserved slot in the output FIFO
    assign inPop = inNotEmpty && ((outCount + inFlight) < scalerPkg::laneDepth);
    assign laneCredit = inPop;

    // The shift travels with the product so a later write cannot reach it
    always_ff @(posedge clk) begin
        if (inPop) begin
            product <= inHead * gainReg;
            productShift <= shiftReg;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            productValid <= 1'b0;
            inFlight <= '0;
        end else begin
            productValid <= inPop;
            inFlight <= inFlight + scalerPkg::laneCntT'(inPop)
                - scalerPkg::laneCntT'(resultValid);
        end
    end

    shiftSaturate i_shiftSaturate (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (productValid),
        .shift    (productShift),
        .dIn      (product),
        .outValid (resultValid),
        .dOut     (result)
    );

    sampleFifo #(
        .payloadT (scalerPkg::resultT),
        .depth    (scalerPkg::laneDepth)
    ) i_outFifo (
        .clk      (clk),
        .arstN    (arstN),
        .push     (resultValid),
        .pushData (result),
        .pop      (outPop),
        .popData  (outData),
        .notEmpty (outNotEmpty),
        .count    (outCount)
    );

endmodule

// ==== rtl/laneCollector.sv ====
`timescale 1ns/1ps

module laneCollector (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [scalerPkg::numLanes-1:0] laneNotEmpty,
    input  scalerPkg::resultT              laneData [scalerPkg::numLanes],
    output logic [scalerPkg::numLanes-1:0] lanePop,
    output logic                           outValid,
    output scalerPkg::laneIdT              outLane,
    output scalerPkg::resultT              outData,
    input  logic                           outCredit
);

    scalerPkg::laneIdT lastLane;
    scalerPkg::laneIdT pick;
    logic found;
    logic popAny;
    scalerPkg::outCntT credit;

    // Search starts just after the last lane served and ends on that lane itself
    always_comb begin
        found = 1'b0;
        pick = lastLane;
        for (int k = 1; k <= scalerPkg::numLanes; k++) begin
            if (!found && laneNotEmpty[scalerPkg::laneIdT'(lastLane + k)]) begin
                found = 1'b1;
                pick = scalerPkg::laneIdT'(lastLane + k);
            end
        end
    end

    assign popAny = found && (credit != '0);

    always_comb begin
        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            lanePop[i] = popAny && (pick == scalerPkg::laneIdT'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (popAny) begin
            outLane <= pick;
            outData <= laneData[pick];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastLane <= '0;
            outValid <= 1'b0;
            credit <= scalerPkg::outCntT'(scalerPkg::outDepth);
        end else begin
            outValid <= popAny;
            if (popAny) begin
                lastLane <= pick;
            end
            credit <= credit + scalerPkg::outCntT'(outCredit)
                - scalerPkg::outCntT'(popAny);
        end
    end

endmodule

// ==== rtl/laneDispatcher.sv ====
`timescale 1ns/1ps

module laneDispatcher (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           inValid,
    input  scalerPkg::laneIdT              inLane,
    input  scalerPkg::sampleT              inSample,
    output logic                           inCredit,
    input  logic                           cfgWrite,
    input  scalerPkg::laneIdT              cfgLane,
    output logic [scalerPkg::numLanes-1:0] laneCfgWrite,
    output logic [scalerPkg::numLanes-1:0] laneValid,
    output scalerPkg::sampleT              laneSample,
    input  logic [scalerPkg::numLanes-1:0] laneCredit
);

    scalerPkg::taggedSampleT pushEntry;
    scalerPkg::taggedSampleT headEntry;
    logic headValid;
    logic send;
    scalerPkg::laneCntT credit [scalerPkg::numLanes];

    assign pushEntry.lane = inLane;
    assign pushEntry.sample = inSample;

    sampleFifo #(
        .payloadT (scalerPkg::taggedSampleT),
        .depth    (scalerPkg::inDepth)
    ) i_inQueue (
        .clk      (clk),
        .arstN    (arstN),
        .push     (inValid),
        .pushData (pushEntry),
        .pop      (send),
        .popData  (headEntry),
        .notEmpty (headValid),
        .count    ()
    );

    // A head entry for a lane without credit blocks the whole queue
    assign send = headValid && (credit[headEntry.lane] != '0);
    assign inCredit = send;
    assign laneSample = headEntry.sample;

    always_comb begin
        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            laneValid[i] = send && (headEntry.lane == scalerPkg::laneIdT'(i));
            laneCfgWrite[i] = cfgWrite && (cfgLane == scalerPkg::laneIdT'(i));
        end
    end

    // Sends and returns on the same lane in one cycle cancel out
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < scalerPkg::numLanes; i++) begin
                credit[i] <= scalerPkg::laneCntT'(scalerPkg::laneDepth);
            end
        end else begin
            for (int i = 0; i < scalerPkg::numLanes; i++) begin
                credit[i] <= credit[i] + scalerPkg::laneCntT'(laneCredit[i])
                    - scalerPkg::laneCntT'(laneValid[i]);
            end
        end
    end

endmodule

// ==== rtl/multiLaneScaler.sv ====
`timescale 1ns/1ps

module multiLaneScaler (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  scalerPkg::laneIdT inLane,
    input  scalerPkg::sampleT inSample,
    output logic              inCredit,
    output logic              outValid,
    output scalerPkg::laneIdT outLane,
    output scalerPkg::resultT outData,
    input  logic              outCredit,
    input  logic              cfgWrite,
    input  scalerPkg::laneIdT cfgLane,
    input  scalerPkg::gainT   cfgGain,
    input  scalerPkg::shiftT  cfgShift
);

    logic [scalerPkg::numLanes-1:0] laneCfgWrite;
    logic [scalerPkg::numLanes-1:0] laneValid;
    logic [scalerPkg::numLanes-1:0] laneCredit;
    logic [scalerPkg::numLanes-1:0] lanePop;
    logic [scalerPkg::numLanes-1:0] laneNotEmpty;
    scalerPkg::sampleT laneSample;
    scalerPkg::resultT laneData [scalerPkg::numLanes];

    laneDispatcher i_dispatcher (
        .clk          (clk),
        .arstN        (arstN),
        .inValid      (inValid),
        .inLane       (inLane),
        .inSample     (inSample),
        .inCredit     (inCredit),
        .cfgWrite     (cfgWrite),
        .cfgLane      (cfgLane),
        .laneCfgWrite (laneCfgWrite),
        .laneValid    (laneValid),
        .laneSample   (laneSample),
        .laneCredit   (laneCredit)
    );

    // Gain and shift go to every lane, only the addressed lane's strobe fires
    for (genvar i = 0; i < scalerPkg::numLanes; i++) begin : gLane
        gainLane i_lane (
            .clk         (clk),
            .arstN       (arstN),
            .cfgWrite    (laneCfgWrite[i]),
            .cfgGain     (cfgGain),
            .cfgShift    (cfgShift),
            .inValid     (laneValid[i]),
            .inSample    (laneSample),
            .laneCredit  (laneCredit[i]),
            .outPop      (lanePop[i]),
            .outData     (laneData[i]),
            .outNotEmpty (laneNotEmpty[i])
        );
    end

    laneCollector i_collector (
        .clk          (clk),
        .arstN        (arstN),
        .laneNotEmpty (laneNotEmpty),
        .laneData     (laneData),
        .lanePop      (lanePop),
        .outValid     (outValid),
        .outLane      (outLane),
        .outData      (outData),
        .outCredit    (outCredit)
    );

endmodule

// ==== rtl/sampleFifo.sv ====
`timescale 1ns/1ps

module sampleFifo #(
    parameter type payloadT = logic [7:0],
    parameter int depth = 4
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         push,
    input  payloadT                      pushData,
    input  logic                         pop,
    output payloadT                      popData,
    output logic                         notEmpty,
    output logic [$clog2(depth+1)-1:0]   count
);

    payloadT mem [depth];
    logic [$clog2(depth)-1:0] wrPtr;
    logic [$clog2(depth)-1:0] rdPtr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            // The sender never pushes into a full buffer, credits guarantee it
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign popData = mem[rdPtr];
    assign notEmpty = (count != '0);

endmodule

// ==== rtl/scalerPkg.sv ====
package scalerPkg;

    localparam int numLanes = 4;
    localparam int laneIdW = 2;

    localparam int sampleW = 18;
    localparam int gainW = 16;
    localparam int productW = 34;
    localparam int shiftW = 5;
    localparam int resultW = 18;

    // Queue depths double as the initial credit counts on each hop
    localparam int inDepth = 4;
    localparam int laneDepth = 4;
    localparam int outDepth = 4;

    localparam int laneCntW = $clog2(laneDepth + 1);
    localparam int outCntW = $clog2(outDepth + 1);

    typedef logic [laneIdW-1:0] laneIdT;
    typedef logic signed [sampleW-1:0] sampleT;
    typedef logic signed [gainW-1:0] gainT;
    typedef logic [shiftW-1:0] shiftT;
    typedef logic signed [productW-1:0] productT;
    typedef logic signed [resultW-1:0] resultT;

    typedef logic [laneCntW-1:0] laneCntT;
    typedef logic [outCntW-1:0] outCntT;

    typedef struct packed {
        laneIdT lane;
        sampleT sample;
    } taggedSampleT;

    // Symmetric limits keep a saturated result off the most negative code
    localparam resultT satPosValue = 18'h1ffff;
    localparam resultT satNegValue = 18'h20001;

endpackage

// ==== rtl/shiftSaturate.sv ====
`timescale 1ns/1ps

module shiftSaturate (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  scalerPkg::shiftT   shift,
    input  scalerPkg::productT dIn,
    output logic               outValid,
    output scalerPkg::resultT  dOut
);

    scalerPkg::productT shifted;
    scalerPkg::productT upper;
    scalerPkg::resultT field;
    logic satPos;
    logic satNeg;
    logic stageValid;
    logic sign;

    // Upper holds bits 33 down to shift+17, so the top bit of the field is part of the check
    always_comb begin
        sign = dIn[scalerPkg::productW-1];
        shifted = dIn >>> shift;
        upper = dIn >>> (shift + 6'd17);
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            if (shift[scalerPkg::shiftW-1]) begin
                // Shifts of 16 and above all keep the top 18 bits
                field <= dIn[scalerPkg::productW-1 -: scalerPkg::resultW];
                satPos <= 1'b0;
                satNeg <= 1'b0;
            end else begin
                field <= shifted[scalerPkg::resultW-1:0];
                satPos <= !sign && (upper != '0);
                satNeg <= sign && (upper != '1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stageValid) begin
            if (satPos) begin
                dOut <= scalerPkg::satPosValue;
            end else if (satNeg) begin
                dOut <= scalerPkg::satNegValue;
            end else begin
                dOut <= field;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            stageValid <= inValid;
            outValid <= stageValid;
        end
    end

endmodule

// ==== verification/multiLaneScalerTb.sv ====
`timescale 1ns/1ps

module multiLaneScalerTb;

    localparam int timeoutCycles = 6000;

    logic clk = 1'b0;
    logic arstN = 1'b0;
    logic inValid = 1'b0;
    scalerPkg::laneIdT inLane = '0;
    scalerPkg::sampleT inSample = '0;
    logic inCredit;
    logic outValid;
    scalerPkg::laneIdT outLane;
    scalerPkg::resultT outData;
    logic outCredit = 1'b0;
    logic cfgWrite = 1'b0;
    scalerPkg::laneIdT cfgLane = '0;
    scalerPkg::gainT cfgGain = '0;
    scalerPkg::shiftT cfgShift = '0;

    logic [31:0] rngState = 32'hb378_cf5a;
    logic idle = 1'b1;
    logic stallMode = 1'b0;
    int tick = 0;
    int sentCount = 0;
    int inReturns = 0;
    int receivedCount = 0;
    int returnedCount = 0;
    scalerPkg::gainT gainMirror [scalerPkg::numLanes] = '{default: '0};
    scalerPkg::shiftT shiftMirror [scalerPkg::numLanes] = '{default: '0};
    scalerPkg::resultT expQ [scalerPkg::numLanes][$];

    multiLaneScaler i_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic failText(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic failValue(input string name, input longint expected, input longint actual);
        failText($sformatf("%s expected %0d, got %0d", name, expected, actual));
    endtask

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // The full product gives either its top 18 bits or a shifted field with symmetric clipping
    function automatic scalerPkg::resultT expectedResult(input scalerPkg::sampleT s,
                                                         input scalerPkg::gainT g,
                                                         input scalerPkg::shiftT sh);
        scalerPkg::productT p;
        scalerPkg::productT shifted;
        logic overflow;
        int satMag;
        p = scalerPkg::productT'(s) * scalerPkg::productT'(g);
        satMag = (1 << (scalerPkg::resultW - 1)) - 1;
        if (sh >= scalerPkg::shiftT'(16)) begin
            return p[scalerPkg::productW-1:scalerPkg::productW-scalerPkg::resultW];
        end
        overflow = 1'b0;
        for (int b = int'(sh) + 17; b < scalerPkg::productW; b++) begin
            if (p[b] != p[scalerPkg::productW-1]) begin
                overflow = 1'b1;
            end
        end
        if (overflow) begin
            return p[scalerPkg::productW-1] ? scalerPkg::resultT'(-satMag)
                                            : scalerPkg::resultT'(satMag);
        end
        shifted = p >>> sh;
        return shifted[scalerPkg::resultW-1:0];
    endfunction

    function automatic int senderCredits();
        return scalerPkg::inDepth - sentCount + inReturns;
    endfunction

    function automatic int pendingResults();
        int total;
        total = 0;
        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            total += expQ[i].size();
        end
        return total;
    endfunction

    task automatic writeConfig(input int lane, input int gain, input int shift);
        cfgWrite = 1'b1;
        cfgLane = scalerPkg::laneIdT'(lane);
        cfgGain = scalerPkg::gainT'(gain);
        cfgShift = scalerPkg::shiftT'(shift);
        gainMirror[lane] = scalerPkg::gainT'(gain);
        shiftMirror[lane] = scalerPkg::shiftT'(shift);
        @(posedge clk);
        #1;
        cfgWrite = 1'b0;
    endtask

    task automatic sendSample(input int lane, input int sample);
        int waited;
        waited = 0;
        while (senderCredits() == 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeoutCycles) failText("no input credit came back before the timeout");
        end
        inValid = 1'b1;
        inLane = scalerPkg::laneIdT'(lane);
        inSample = scalerPkg::sampleT'(sample);
        sentCount++;
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic sendBurst(input int count);
        for (int n = 0; n < count; n++) begin
            sendSample(int'(nextRandom() % scalerPkg::numLanes), int'(nextRandom()));
        end
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while (pendingResults() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeoutCycles) failText("results were still missing at the drain timeout");
        end
    endtask

    // The receiver hands a credit back for each result it has taken
    always @(posedge clk) begin : creditPolicy
        tick++;
        #1;
        if ((receivedCount > returnedCount) &&
            (stallMode ? ((tick % 200 >= 150) && (tick % 5 == 0)) : (tick % 3 != 0))) begin
            outCredit = 1'b1;
            returnedCount++;
        end else begin
            outCredit = 1'b0;
        end
    end

    always @(negedge clk) begin : monitor
        scalerPkg::laneIdT lane;
        if (arstN) begin
            if (inValid) begin
                expQ[inLane].push_back(expectedResult(inSample, gainMirror[inLane],
                                                      shiftMirror[inLane]));
            end
            if (inCredit) begin
                inReturns++;
                assert (senderCredits() <= scalerPkg::inDepth)
                    else failText("inCredit returned more credits than the sender had spent");
            end
            if (outValid) begin
                lane = outLane;
                assert (scalerPkg::outDepth + returnedCount - int'(outCredit) - receivedCount > 0)
                    else failText("outValid fired while no output credit was granted");
                assert (expQ[lane].size() > 0)
                    else failText($sformatf("result on lane %0d with nothing expected", lane));
                assert (outData == expQ[lane][0])
                    else failValue("outData", longint'(expQ[lane][0]), longint'(outData));
                void'(expQ[lane].pop_front());
                receivedCount++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) idle |-> (!outValid && !inCredit))
        else failText("outValid or inCredit rose before any sample was sent");
    assert property (@(posedge clk) disable iff (!arstN) idle |-> (i_dut.laneNotEmpty == '0))
        else failText("a lane output FIFO filled before any sample was sent");

    initial begin
        logic [31:0] r;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        idle = 1'b0;

        // Gains within 8 bits against shifts of 8 and up never leave the field
        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            r = nextRandom();
            writeConfig(i, int'($signed(r[7:0])), 8 + int'(r[10:8]));
        end
        sendBurst(60);
        waitDrained();

        // 1024 * 128 sets only the top field bit
        // -8 * 16385 clears that bit under a negative sign
        r = nextRandom();
        writeConfig(0, 128, 0);
        writeConfig(1, 16385, 0);
        writeConfig(2, 1000, 0);
        writeConfig(3, int'($signed(r[15:0])), 3);
        sendSample(0, 1024);
        sendSample(0, -1024);
        sendSample(0, 1023);
        sendSample(1, -8);
        sendSample(1, 8);
        sendSample(2, 1000);
        sendSample(2, -1000);
        sendSample(2, 131);
        sendBurst(40);
        waitDrained();

        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            r = nextRandom();
            writeConfig(i, int'($signed(r[15:0])), 16 + 4 * i + int'(r[17:16]));
        end
        sendBurst(60);
        waitDrained();

        // Long stretches without output credits push back all the way to the sender
        for (int i = 0; i < scalerPkg::numLanes; i++) begin
            r = nextRandom();
            writeConfig(i, int'($signed(r[15:0])), int'(r[20:16]));
        end
        stallMode = 1'b1;
        sendBurst(120);
        waitDrained();

        if (senderCredits() == scalerPkg::inDepth) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            failText("the sender had not got all input credits back after the final drain");
        end
    end

endmodule
